// ==== vlog.f ====
adder_types_pkg.sv
prefix_net_pkg.sv
pg_capture.sv
han_carlson_tree.sv
sum_register.sv
hc_adder.sv
tb_hc_adder.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_hc_adder
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "run incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_hc_adder.sv ====
`timescale 1ns/1ps

module tb_hc_adder;

        import adder_types_pkg::*;

        // roughly 400 cycles of tests and five times that as the limit
        localparam int max_cycles = 2000;
        localparam int stream_len = 200;
        localparam int gap_len    = 100;

        logic     clk;
        logic     rst_n;
        logic     in_valid;
        operand_t operand;
        result_t  result;
        logic     out_valid;

        result_t     exp_q[$];
        result_t     mon_exp;
        logic [1:0]  vpipe;
        logic [31:0] lfsr_state;
        string       cur_test;
        int          cycles;
        int          pass_count;
        int          fail_count;

        hc_adder hc_adder_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .operand   (operand),
                .result    (result),
                .out_valid (out_valid)
        );

        always #50 clk = ~clk;

        always @(posedge clk) begin
                cycles++;
                if (cycles >= max_cycles) begin
                        $display("timeout: run did not finish within %0d cycles", max_cycles);
                        $display("Simulation failed");
                        $finish;
                end
        end

        // galois lfsr stepped once per random bit
        function automatic logic rand_bit();
                logic b;
                b = lfsr_state[0];
                lfsr_state = lfsr_state >> 1;
                if (b) begin
                        lfsr_state = lfsr_state ^ 32'h80200003;
                end
                return b;
        endfunction

        function automatic logic [data_w-1:0] rand_word();
                logic [data_w-1:0] w;
                w = '0;
                for (int i = 0; i < data_w; i++) begin
                        w[i] = rand_bit();
                end
                return w;
        endfunction

        // plain 65-bit addition as the reference
        function automatic result_t ref_add(input operand_t op);
                logic [data_w:0] s;
                result_t r;
                s = {1'b0, op.a} + {1'b0, op.b} + {{data_w{1'b0}}, op.cin};
                r.sum  = s[data_w-1:0];
                r.cout = s[data_w];
                return r;
        endfunction

        task automatic check_result(input string name, input result_t exp, input result_t act);
                if (act !== exp) begin
                        fail_count++;
                        $display("FAIL %s: expected sum %h cout %b, actual sum %h cout %b",
                                 name, exp.sum, exp.cout, act.sum, act.cout);
                end else begin
                        pass_count++;
                end
        endtask

        task automatic check_valid(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        fail_count++;
                        $display("FAIL %s: expected out_valid %b, actual out_valid %b",
                                 name, exp, act);
                end else begin
                        pass_count++;
                end
        endtask

        // out_valid must mirror in_valid two cycles later
        always @(negedge clk) begin
                if (rst_n) begin
                        check_valid(cur_test, vpipe[1], out_valid);
                        if (out_valid === 1'b1) begin
                                if (exp_q.size() == 0) begin
                                        fail_count++;
                                        $display("%s: out_valid came with no operand pending",
                                                 cur_test);
                                end else begin
                                        mon_exp = exp_q.pop_front();
                                        check_result(cur_test, mon_exp, result);
                                end
                        end
                end
                vpipe = {vpipe[0], in_valid};
        end

        task automatic next_cycle();
                @(posedge clk);
                #1;
        endtask

        task automatic issue(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                             input logic cin);
                operand_t op;
                op.a = a;
                op.b = b;
                op.cin = cin;
                operand = op;
                in_valid = 1'b1;
                exp_q.push_back(ref_add(op));
                next_cycle();
                in_valid = 1'b0;
        endtask

        // wait for every pending result and a short idle tail
        task automatic drain();
                while (exp_q.size() != 0) begin
                        next_cycle();
                end
                next_cycle();
                next_cycle();
        endtask

        task automatic report_test(input string name, input int fails_before);
                if (fail_count == fails_before) begin
                        $display("%s: passed", name);
                end else begin
                        $display("%s: %0d errors", name, fail_count - fails_before);
                end
        endtask

        task automatic test_reset();
                int fails_before;
                fails_before = fail_count;
                cur_test = "test_reset";
                repeat (10) begin
                        next_cycle();
                        check_valid(cur_test, 1'b0, out_valid);
                end
                rst_n = 1'b1;
                repeat (3) begin
                        next_cycle();
                        check_valid(cur_test, 1'b0, out_valid);
                end
                report_test(cur_test, fails_before);
        endtask

        task automatic test_corners();
                int fails_before;
                fails_before = fail_count;
                cur_test = "test_corners";
                issue('0, '0, 1'b0);
                drain();
                issue('1, '0, 1'b1);
                drain();
                issue('1, '1, 1'b0);
                drain();
                issue('1, '1, 1'b1);
                drain();
                issue({data_w/2{2'b01}}, {data_w/2{2'b10}}, 1'b1);
                drain();
                issue({data_w/2{2'b10}}, {data_w/2{2'b10}}, 1'b0);
                drain();
                // generate at bit 0 rippling through a propagate chain up to bit 63
                issue('1, {{(data_w-1){1'b0}}, 1'b1}, 1'b0);
                drain();
                report_test(cur_test, fails_before);
        endtask

        task automatic test_spans();
                int fails_before;
                int span;
                int k;
                logic [data_w-1:0] prop;
                logic [data_w-1:0] gen;
                fails_before = fail_count;
                cur_test = "test_spans";
                for (int s = 0; s < 6; s++) begin
                        span = 1 << s;
                        for (int j = 0; j < 2; j++) begin
                                // odd and even start bit
                                k = (j == 0) ? 7 : 24;
                                gen  = 64'h1 << k;
                                prop = ((64'h1 << span) - 64'h1) << (k + 1);
                                issue(prop | gen, gen, 1'b0);
                                drain();
                        end
                end
                report_test(cur_test, fails_before);
        endtask

        task automatic test_random_stream();
                int fails_before;
                logic [data_w-1:0] a;
                logic [data_w-1:0] b;
                logic cin;
                fails_before = fail_count;
                cur_test = "test_random_stream";
                for (int n = 0; n < stream_len; n++) begin
                        a = rand_word();
                        b = rand_word();
                        cin = rand_bit();
                        issue(a, b, cin);
                end
                drain();
                report_test(cur_test, fails_before);
        endtask

        task automatic test_gaps();
                int fails_before;
                logic [data_w-1:0] a;
                logic [data_w-1:0] b;
                logic cin;
                fails_before = fail_count;
                cur_test = "test_gaps";
                for (int n = 0; n < gap_len; n++) begin
                        if (rand_bit()) begin
                                a = rand_word();
                                b = rand_word();
                                cin = rand_bit();
                                issue(a, b, cin);
                        end else begin
                                next_cycle();
                        end
                end
                drain();
                report_test(cur_test, fails_before);
        endtask

        initial begin
                clk = 1'b0;
                rst_n = 1'b0;
                in_valid = 1'b0;
                operand = '0;
                vpipe = 2'b00;
                lfsr_state = 32'h68749150;
                cur_test = "startup";
                cycles = 0;
                pass_count = 0;
                fail_count = 0;
                test_reset();
                test_corners();
                test_spans();
                test_random_stream();
                test_gaps();
                $display("checks: %0d passed, %0d failed", pass_count, fail_count);
                if (fail_count == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

// ==== hc_adder.sv ====
`timescale 1ns/1ps

module hc_adder (
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic                       in_valid,
        input  adder_types_pkg::operand_t  operand,
        output adder_types_pkg::result_t   result,
        output logic                       out_valid
);

        import adder_types_pkg::*;

        pg_t               pg;
        logic              pg_valid;
        logic [data_w-1:0] grp_g;

        // operand register and p/g forming
        pg_capture pg_capture_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .in_valid (in_valid),
                .operand  (operand),
                .pg       (pg),
                .pg_valid (pg_valid)
        );

        // prefix tree between the two registers
        han_carlson_tree han_carlson_tree_i (
                .pg    (pg),
                .grp_g (grp_g)
        );

        // sum and carry-out register
        sum_register sum_register_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .pg        (pg),
                .pg_valid  (pg_valid),
                .grp_g     (grp_g),
                .result    (result),
                .out_valid (out_valid)
        );

endmodule

// ==== sum_register.sv ====
`timescale 1ns/1ps

module sum_register (
        input  logic                                clk,
        input  logic                                rst_n,
        input  adder_types_pkg::pg_t                pg,
        input  logic                                pg_valid,
        input  logic [adder_types_pkg::data_w-1:0]  grp_g,
        output adder_types_pkg::result_t            result,
        output logic                                out_valid
);

        import adder_types_pkg::*;

        result_t result_d;

        // grp_g[i] is the carry into operand bit i
        always_comb begin
                result_d.sum  = pg.p[data_w:1] ^ grp_g;
                result_d.cout = pg.g[data_w] | (pg.p[data_w] & grp_g[data_w-1]);
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= pg_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (pg_valid) begin
                        result <= result_d;
                end
        end

endmodule

// ==== han_carlson_tree.sv ====
`timescale 1ns/1ps

module han_carlson_tree (
        input  adder_types_pkg::pg_t                pg,
        output logic [adder_types_pkg::data_w-1:0]  grp_g
);

        import adder_types_pkg::*;
        import prefix_net_pkg::*;

        // index 0 is the brent-kung level and index n the n-th kogge-stone level
        logic [ks_levels:0][data_w-1:0] gg;
        logic [ks_levels:0][data_w-1:0] gp;

        // brent-kung level
        // each odd position absorbs its even neighbour
        for (genvar i = 0; i < data_w; i++) begin : g_bk
                if (is_odd(i)) begin : g_cell
                        assign gg[0][i] = pg.g[i] | (pg.p[i] & pg.g[i-1]);
                        assign gp[0][i] = pg.p[i] & pg.p[i-1];
                end else begin : g_pass
                        assign gg[0][i] = pg.g[i];
                        assign gp[0][i] = pg.p[i];
                end
        end

        // kogge-stone levels on odd positions only
        for (genvar n = 1; n <= ks_levels; n++) begin : g_ks
                localparam int span = ks_span(n);

                for (genvar i = 0; i < data_w; i++) begin : g_bit
                        if (is_odd(i) && i >= ks_first(n)) begin : g_cell
                                assign gg[n][i] = gg[n-1][i] |
                                                  (gp[n-1][i] & gg[n-1][i-span]);
                                assign gp[n][i] = gp[n-1][i] & gp[n-1][i-span];
                        end else begin : g_pass
                                // even positions and low odd positions ride through
                                assign gg[n][i] = gg[n-1][i];
                                assign gp[n][i] = gp[n-1][i];
                        end
                end
        end

        // fix-up level
        // each even position picks up the finished carry from the odd one below
        for (genvar i = 0; i < data_w; i++) begin : g_fix
                if (!is_odd(i) && i > 0) begin : g_even
                        assign grp_g[i] = gg[ks_levels][i] |
                                          (gp[ks_levels][i] & gg[ks_levels][i-1]);
                end else begin : g_keep
                        // position 0 is the carry-in itself
                        assign grp_g[i] = gg[ks_levels][i];
                end
        end

endmodule

// ==== pg_capture.sv ====
`timescale 1ns/1ps

module pg_capture (
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic                       in_valid,
        input  adder_types_pkg::operand_t  operand,
        output adder_types_pkg::pg_t       pg,
        output logic                       pg_valid
);

        import adder_types_pkg::*;

        pg_t pg_d;

        // bit 0 is the carry-in term and only ever generates
        always_comb begin
                pg_d.p = {operand.a ^ operand.b, 1'b0};
                pg_d.g = {operand.a & operand.b, operand.cin};
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pg_valid <= 1'b0;
                end else begin
                        pg_valid <= in_valid;
                end
        end

        // payload loads only with a strobe
        always_ff @(posedge clk) begin
                if (in_valid) begin
                        pg <= pg_d;
                end
        end

endmodule

// ==== prefix_net_pkg.sv ====
package prefix_net_pkg;

        // kogge-stone levels on the odd positions
        // the brent-kung level already covers span 1 so one level fewer than log2
        localparam int ks_levels = $clog2(adder_types_pkg::data_w) - 1;

        // bit distance combined at kogge-stone level n counting from 1
        function automatic int ks_span(input int n);
                int span;
                span = 1;
                for (int k = 0; k < n; k++) begin
                        span = span * 2;
                end
                return span;
        endfunction

        // lowest odd position that still finds a partner at level n
        // position 1 holds a complete prefix once the brent-kung level is done
        function automatic int ks_first(input int n);
                return ks_span(n) + 1;
        endfunction

        // odd positions take part in the kogge-stone levels while even ones wait
        function automatic bit is_odd(input int pos);
                return (pos % 2) == 1;
        endfunction

endpackage

// ==== adder_types_pkg.sv ====
package adder_types_pkg;

        // operand width of the adder
        localparam int data_w = 64;

        // one operand set as presented at the input
        typedef struct packed {
                logic [data_w-1:0] a;
                logic [data_w-1:0] b;
                logic              cin;
        } operand_t;

        // per-bit propagate and generate
        // position 0 carries the carry-in and position i+1 belongs to operand bit i
        typedef struct packed {
                logic [data_w:0] p;
                logic [data_w:0] g;
        } pg_t;

        // registered adder output
        typedef struct packed {
                logic [data_w-1:0] sum;
                logic              cout;
        } result_t;

endpackage
